// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_top
FILELIST  := project.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: dvi_pkg.sv
package dvi_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int h_width        = 11; // output x, up to 2x native
    localparam int v_width        = 10; // output y, 2x native rows
    localparam int color_width    = 4;  // palette index
    localparam int raster_x_width = 10; // native x from the video chip

    // chip codes as strapped on the board
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6569r3   = 2'd1,
        chip_6567r56a = 2'd2,
        chip_6569r1   = 2'd3
    } chip_t;

    // one frame worth of window edges
    typedef struct packed {
        logic [h_width-1:0] max_width;  // last h_count before wrap
        logic [h_width-1:0] ha_end;     // last active column
        logic [h_width-1:0] hs_sta;     // hsync start, inclusive
        logic [h_width-1:0] hs_end;     // hsync end, exclusive
        logic [h_width-1:0] ha_sta;     // active starts after this column
        logic [v_width-1:0] max_height; // last v_count before wrap
        logic [v_width-1:0] va_end;     // vertical blank starts here
        logic [v_width-1:0] vs_sta;
        logic [v_width-1:0] vs_end;
        logic [v_width-1:0] va_sta;     // vertical blank ends here
    } frame_timing_t;

    typedef struct packed {
        logic [h_width-1:0] h_count;
        logic [v_width-1:0] v_count;
        logic               half_bright; // odd output row of a doubled pair
    } scan_pos_t;

    typedef struct packed {
        logic                   hsync;
        logic                   vsync;
        logic                   active;
        logic [color_width-1:0] pixel_color;
    } video_out_t;

    // ------------------------------
    // per-chip tables at reduced dvi clock
    // ------------------------------
    // 945 x 624, 29.56 MHz
    localparam frame_timing_t pal_timing = '{
        11'd944, 11'd914, 11'd0, 11'd64, 11'd132,
        10'd623, 10'd592, 10'd7, 10'd12, 10'd17
    };

    // 845 x 526, 26.59 MHz
    localparam frame_timing_t ntsc_r8_timing = '{
        11'd844, 11'd826, 11'd11, 11'd75, 11'd106,
        10'd525, 10'd20, 10'd22, 10'd44, 10'd66
    };

    // 832 x 524, same clock as r8
    localparam frame_timing_t ntsc_r56_timing = '{
        11'd831, 11'd814, 11'd2, 11'd66, 11'd90,
        10'd523, 10'd22, 10'd24, 10'd46, 10'd66
    };

endpackage

// File: dvi_sync_top.sv
module dvi_sync_top
    import dvi_pkg::*;
(
    input  logic                      clk_dvi,
    input  logic                      rst,
    input  chip_t                     chip,
    input  logic                      hpolarity,
    input  logic                      vpolarity,
    input  logic                      enable_csync,
    input  logic [raster_x_width-1:0] raster_x,
    input  logic                      pixel_strobe,
    input  logic [color_width-1:0]    pixel_color,
    output video_out_t                video,
    output logic                      half_bright
);

    frame_timing_t timing;
    scan_pos_t     pos;

    // ------------------------------
    // stages
    // ------------------------------
    timing_table timing_i (.chip(chip), .timing(timing));

    scan_counter scan_i (.clk_dvi(clk_dvi), .rst(rst), .timing(timing), .pos(pos));

    sync_shaper shaper_i (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .timing       (timing),
        .pos          (pos),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .hsync        (video.hsync),
        .vsync        (video.vsync),
        .active       (video.active)
    );

    line_store store_i (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .raster_x     (raster_x),
        .pixel_strobe (pixel_strobe),
        .pixel_in     (pixel_color),
        .h_count      (pos.h_count), // only the column is needed here
        .pixel_out    (video.pixel_color)
    );

    // match the 1 cycle of the sync and pixel paths
    always_ff @(posedge clk_dvi) begin
        if (!rst) half_bright <= 1'b0;
        else      half_bright <= pos.half_bright;
    end

endmodule

// File: line_store.sv
module line_store
    import dvi_pkg::*;
(
    input  logic                      clk_dvi,
    input  logic                      rst,
    input  logic [raster_x_width-1:0] raster_x,     // native write column
    input  logic                      pixel_strobe, // one pixel per high edge
    input  logic [color_width-1:0]    pixel_in,
    input  logic [h_width-1:0]        h_count,      // output read column
    output logic [color_width-1:0]    pixel_out
);

    // two lines deep, sized to the full h_count range
    logic [color_width-1:0] buf0 [2**h_width];
    logic [color_width-1:0] buf1 [2**h_width];

    logic               sel;      // 0 = write buf0, read buf1
    logic               swap;     // strobe at start of native line
    logic               wr_sel;   // buffer taking this write
    logic               we;
    logic [h_width-1:0] wr_addr;

    assign swap    = pixel_strobe && (raster_x == '0);
    assign wr_sel  = swap ? ~sel : sel; // column 0 already goes to the fresh line
    assign we      = rst && pixel_strobe;
    assign wr_addr = {1'b0, raster_x};

    // ------------------------------
    // select flip
    // ------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            sel <= 1'b0;
        end else if (swap) begin
            sel <= ~sel;
        end
    end

    // write side, native raster
    always_ff @(posedge clk_dvi) begin
        if (we && !wr_sel) buf0[wr_addr] <= pixel_in;
        if (we &&  wr_sel) buf1[wr_addr] <= pixel_in;
    end

    // ------------------------------
    // read side, one line behind
    // ------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            pixel_out <= '0;
        end else begin
            pixel_out <= sel ? buf0[h_count] : buf1[h_count]; // the line not being filled
        end
    end

endmodule

// File: project.f
dvi_pkg.sv
timing_table.sv
scan_counter.sv
sync_shaper.sv
line_store.sv
dvi_sync_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// File: scan_counter.sv
module scan_counter
    import dvi_pkg::*;
(
    input  logic          clk_dvi,
    input  logic          rst,
    input  frame_timing_t timing,
    output scan_pos_t     pos
);

    logic h_wrap; // last column of the row
    logic v_wrap; // last row of the frame

    assign h_wrap = (pos.h_count >= timing.max_width);
    assign v_wrap = (pos.v_count >= timing.max_height);

    // ------------------------------
    // raster walk
    // ------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            pos.h_count     <= '0;
            pos.v_count     <= '0;
            pos.half_bright <= 1'b0;
        end else begin
            if (!h_wrap) begin
                pos.h_count <= pos.h_count + 1'b1;
            end else begin
                pos.h_count <= '0;
                if (!v_wrap) begin
                    pos.v_count     <= pos.v_count + 1'b1;
                    pos.half_bright <= ~pos.half_bright; // every other output row
                end else begin
                    // frame start, row 0 is always the bright one
                    pos.v_count     <= '0;
                    pos.half_bright <= 1'b0;
                end
            end
        end
    end

    // each native row is shown twice, so half_bright marks
    // the repeat and the display can dim it for a scanline look

endmodule

// File: sync_shaper.sv
module sync_shaper
    import dvi_pkg::*;
(
    input  logic          clk_dvi,
    input  logic          rst,
    input  frame_timing_t timing,
    input  scan_pos_t     pos,
    input  logic          hpolarity,    // 1 = active high hsync
    input  logic          vpolarity,    // 1 = active high vsync
    input  logic          enable_csync, // merge vsync into hsync
    output logic          hsync,
    output logic          vsync,
    output logic          active
);

    logic [h_width-1:0] h;
    logic [v_width-1:0] v;
    logic hs_raw, vs_raw, cs_raw;
    logic vs_after_sta, vs_before_end;
    logic vb_after_end, vb_before_sta, vblank;
    logic h_active;

    assign h = pos.h_count;
    assign v = pos.v_count;

    // ------------------------------
    // raw windows, active high
    // ------------------------------
    assign hs_raw = (h >= timing.hs_sta) && (h < timing.hs_end);

    // vsync edges land on hsync columns, ordered row then column
    assign vs_after_sta  = (v > timing.vs_sta) || (v == timing.vs_sta && h >= timing.hs_sta);
    assign vs_before_end = (v < timing.vs_end) || (v == timing.vs_end && h < timing.hs_end);
    assign vs_raw        = vs_after_sta && vs_before_end;
    assign cs_raw        = hs_raw | vs_raw;

    // blank from (va_end, ha_sta) up to (va_sta, ha_sta)
    assign vb_after_end  = (v > timing.va_end) || (v == timing.va_end && h >= timing.ha_sta);
    assign vb_before_sta = (v < timing.va_sta) || (v == timing.va_sta && h < timing.ha_sta);
    // window crosses the frame wrap when it ends above where it starts
    assign vblank   = (timing.va_end > timing.va_sta) ? (vb_after_end | vb_before_sta)
                                                      : (vb_after_end & vb_before_sta);
    assign h_active = (h > timing.ha_sta) && (h <= timing.ha_end);

    // ------------------------------
    // polarity, csync merge, register
    // ------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hsync  <= ~hpolarity; // parked at inactive level
            vsync  <= ~vpolarity;
            active <= 1'b0;
        end else begin
            if (enable_csync) begin
                hsync <= hpolarity ? cs_raw : ~cs_raw;
                vsync <= 1'b0; // unused line held low
            end else begin
                hsync <= hpolarity ? hs_raw : ~hs_raw;
                vsync <= vpolarity ? vs_raw : ~vs_raw;
            end
            active <= h_active && !vblank;
        end
    end

endmodule

// File: tb_checker.sv
module tb_checker
    import dvi_pkg::*;
(
    input  logic       clk_dvi,
    input  logic       rst,
    input  chip_t      chip,
    input  logic       hpolarity,
    input  logic       vpolarity,
    input  logic       enable_csync,
    input  logic [9:0] raster_x,
    input  logic       pixel_strobe,
    input  logic [3:0] pixel_color,
    input  video_out_t video,
    input  logic       half_bright,
    output int         errors,
    output int         checks
);

    // ------------------------------
    // reference tables, rows pal / ntsc r8 / ntsc r56
    // ------------------------------
    // columns max_w ha_end hs_sta hs_end ha_sta max_h va_end vs_sta vs_end va_sta
    localparam int timing_tab [3][10] = '{
        '{944, 914,  0, 64, 132, 623, 592,  7, 12, 17},
        '{844, 826, 11, 75, 106, 525,  20, 22, 44, 66},
        '{831, 814,  2, 66,  90, 523,  22, 24, 46, 66}
    };

    int         row;              // table row of the current chip
    int         m_h, m_v, m_sel;  // model counters and buffer select
    logic       m_hb;
    logic [3:0] mbuf [2][2048];   // mirror of both line buffers
    bit         known [2][2048];  // entry has been written
    logic       exp_hs, exp_vs, exp_act, exp_hb;
    logic [3:0] exp_pix;
    logic       pix_known;
    logic       started = 1'b0;

    function automatic int table_row(input chip_t c);
        if (c == chip_6567r8) return 1;
        if (c == chip_6567r56a) return 2;
        return 0; // both 6569 revisions
    endfunction

    // expected {hsync, vsync, active} for one scan position
    function automatic logic [2:0] expect_video(input int h, input int v, input logic hp,
                                                input logic vp, input logic cs);
        int   p;
        int   vb_a;
        int   vb_b;
        logic hs_raw;
        logic vs_raw;
        logic vblank;
        logic act;
        logic hs_o;
        logic vs_o;
        p      = v * 2048 + h; // row then column order
        hs_raw = (h >= timing_tab[row][2]) && (h < timing_tab[row][3]);
        vs_raw = (p >= timing_tab[row][7] * 2048 + timing_tab[row][2]) &&
                 (p <  timing_tab[row][8] * 2048 + timing_tab[row][3]);
        vb_a   = timing_tab[row][6] * 2048 + timing_tab[row][4];
        vb_b   = timing_tab[row][9] * 2048 + timing_tab[row][4];
        vblank = (vb_a > vb_b) ? (p >= vb_a || p < vb_b) : (p >= vb_a && p < vb_b);
        act    = !vblank && (h > timing_tab[row][4]) && (h <= timing_tab[row][1]);
        hs_o   = cs ? (hs_raw | vs_raw) : hs_raw;
        hs_o   = hp ? hs_o : ~hs_o;
        vs_o   = cs ? 1'b0 : (vp ? vs_raw : ~vs_raw);
        return {hs_o, vs_o, act};
    endfunction

    // ------------------------------
    // model, one step per rising edge
    // ------------------------------
    always @(posedge clk_dvi) begin
        int x;
        int wsel;
        started = 1'b1;
        row     = table_row(chip);
        if (!rst) begin
            {exp_hs, exp_vs, exp_act} = {~hpolarity, ~vpolarity, 1'b0}; // idle levels
            exp_hb    = 1'b0;
            exp_pix   = 4'd0;
            pix_known = 1'b1;
            m_h       = 0;
            m_v       = 0;
            m_hb      = 1'b0;
            m_sel     = 0;
        end else begin
            {exp_hs, exp_vs, exp_act} = expect_video(m_h, m_v, hpolarity, vpolarity,
                                                     enable_csync);
            exp_hb    = m_hb;
            exp_pix   = mbuf[1 - m_sel][m_h]; // read side is the other buffer
            pix_known = known[1 - m_sel][m_h];
            if (m_h == timing_tab[row][0]) begin
                m_h = 0;
                if (m_v == timing_tab[row][5]) begin
                    m_v  = 0;
                    m_hb = 1'b0; // frame start
                end else begin
                    m_v  = m_v + 1;
                    m_hb = ~m_hb;
                end
            end else begin
                m_h = m_h + 1;
            end
            if (pixel_strobe) begin
                x    = int'(raster_x);
                wsel = (x == 0) ? 1 - m_sel : m_sel; // line start flips first
                mbuf[wsel][x]  = pixel_color;
                known[wsel][x] = 1'b1;
                m_sel = wsel;
            end
        end
    end

    task automatic check_field(input string what, input logic [3:0] got,
                               input logic [3:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // compare on the falling edge, both sides settled
    initial begin
        errors = 0;
        checks = 0;
        forever begin
            @(negedge clk_dvi);
            if (started) begin
                check_field("hsync", {3'b000, video.hsync}, {3'b000, exp_hs});
                check_field("vsync", {3'b000, video.vsync}, {3'b000, exp_vs});
                check_field("active", {3'b000, video.active}, {3'b000, exp_act});
                check_field("half_bright", {3'b000, half_bright}, {3'b000, exp_hb});
                if (pix_known) check_field("pixel_color", video.pixel_color, exp_pix);
            end
        end
    end

endmodule

// File: tb_clock.sv
module tb_clock (
    input  logic reset_req, // restart the reset window
    output logic clk_dvi,
    output logic rst
);

    logic [3:0] rst_cnt; // cycles of reset still to go

    initial begin
        clk_dvi = 1'b0;
        rst     = 1'b0;  // held from time 0
        rst_cnt = 4'd10;
    end

    always #50 clk_dvi = ~clk_dvi; // period 100

    // counter on the rising edge, rst moves on the falling edge like any input
    always @(posedge clk_dvi) begin
        if (reset_req) rst_cnt <= 4'd10;
        else if (rst_cnt != 4'd0) rst_cnt <= rst_cnt - 4'd1;
    end

    always @(negedge clk_dvi) rst <= (rst_cnt == 4'd0);

endmodule

// File: tb_top.sv
module tb_top
    import dvi_pkg::*;
();

    // frame lengths in clocks per table
    localparam int    pal_frame   = 945 * 624;
    localparam int    r8_frame    = 845 * 526;
    localparam int    r56_frame   = 832 * 524;
    localparam longint all_frames = 2 * pal_frame + r8_frame + r56_frame;
    localparam longint watchdog_time = all_frames * 3 / 2 * 100; // 1.5x in time units

    logic       clk_dvi, rst, reset_req;
    chip_t      chip;
    logic       hpolarity, vpolarity, enable_csync;
    logic [9:0] raster_x;
    logic       pixel_strobe;
    logic [3:0] pixel_color;
    video_out_t video;
    logic       half_bright;
    int         errors, checks;
    logic [31:0] lcg_state;
    int          x_next;

    tb_clock clock_i (.reset_req(reset_req), .clk_dvi(clk_dvi), .rst(rst));

    dvi_sync_top dut_i (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .chip         (chip),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .raster_x     (raster_x),
        .pixel_strobe (pixel_strobe),
        .pixel_color  (pixel_color),
        .video        (video),
        .half_bright  (half_bright)
    );

    tb_checker check_i (
        .clk_dvi(clk_dvi), .rst(rst), .chip(chip), .hpolarity(hpolarity),
        .vpolarity(vpolarity), .enable_csync(enable_csync), .raster_x(raster_x),
        .pixel_strobe(pixel_strobe), .pixel_color(pixel_color), .video(video),
        .half_bright(half_bright), .errors(errors), .checks(checks)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------
    // native pixel stream
    // ------------------------------
    initial begin
        raster_x     = 10'd0;
        pixel_strobe = 1'b0;
        pixel_color  = 4'd0;
        lcg_state    = 32'hdcad;
        x_next       = 0;
        forever begin
            @(negedge clk_dvi);
            if (!pixel_strobe) begin  // strobe every other clock
                pixel_strobe = 1'b1;
                raster_x     = 10'(x_next);
                lcg_state    = lcg_next(lcg_state);
                pixel_color  = lcg_state[19:16];
                x_next       = (x_next == 519) ? 0 : x_next + 1;
            end else begin
                pixel_strobe = 1'b0;
            end
        end
    end

    // reset and set chip and mode while held, then run 1.2 frames
    task automatic run_frames(input chip_t c, input logic hp, input logic vp,
                              input logic cs, input int frame_len);
        @(negedge clk_dvi);
        reset_req = 1'b1;
        @(negedge clk_dvi);
        reset_req = 1'b0;
        @(negedge clk_dvi);
        chip         = c; // rst is low here
        hpolarity    = hp;
        vpolarity    = vp;
        enable_csync = cs;
        while (!rst) @(negedge clk_dvi);
        repeat (frame_len * 6 / 5) @(negedge clk_dvi);
    endtask

    initial begin
        reset_req    = 1'b0;
        chip         = chip_6569r3;
        hpolarity    = 1'b1;
        vpolarity    = 1'b1;
        enable_csync = 1'b0;
        run_frames(chip_6569r3, 1'b1, 1'b1, 1'b0, pal_frame);
        run_frames(chip_6567r8, 1'b0, 1'b0, 1'b0, r8_frame);
        run_frames(chip_6567r56a, 1'b0, 1'b1, 1'b1, r56_frame);
        run_frames(chip_6569r1, 1'b1, 1'b0, 1'b0, pal_frame); // mixed polarity
        @(posedge clk_dvi); // counts only move on the falling edge
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_time);
        $display("watchdog expired before the test sequence completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: timing_table.sv
module timing_table
    import dvi_pkg::*;
(
    input  chip_t         chip,
    output frame_timing_t timing
);

    // ------------------------------
    // chip to table lookup
    // ------------------------------
    // pure decode, chip is only moved while in reset
    always_comb begin
        case (chip)
            chip_6569r1,
            chip_6569r3: begin
                timing = pal_timing; // both pal revisions share one raster
            end
            chip_6567r8: begin
                timing = ntsc_r8_timing;
            end
            chip_6567r56a: begin
                timing = ntsc_r56_timing; // old ntsc, one column shorter per native line
            end
            default: begin
                timing = pal_timing;
            end
        endcase
    end

    // notes on the tables
    //   pal      576 visible rows, blank wraps over frame end
    //   ntsc r8  480 visible rows, blank sits inside the frame
    //   ntsc r56 480 visible rows, same as r8 but 2 rows later
    // sync_shaper copes with both blank layouts by comparing
    // va_end against va_sta

endmodule
